/* aes_col.f */
+incdir+.
aes_col_pkg.sv
aes_col_ctl_if.sv
aes_col_key_if.sv
aes_sbox.sv
aes_control_unit.sv
aes_datapath.sv
aes_key_schedule.sv
aes_col_core.sv
tb_clock_gen.sv
tb_aes_col_core.sv

/* aes_col_core.sv */
// AES-128 column-serial core top: control unit, datapath and key schedule
module aes_col_core import aes_col_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic disable_core,
	input op_mode_t operation_mode,
	input logic ctr_mode,
	input block_t key_in,
	input block_t data_in,
	input block_t iv_in,
	input logic iv_load,
	output block_t data_out,
	output block_t key_out,
	output logic end_comp,
	output logic busy
);

	// Strobes and the shared round-key path
	aes_col_ctl_if ctl_if ();
	aes_col_key_if key_if ();

	aes_control_unit u_ctl (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.disable_core(disable_core),
		.operation_mode(operation_mode),
		.ctr_mode(ctr_mode),
		.end_comp(end_comp),
		.busy(busy),
		.ctl(ctl_if.ctl)
	);

	aes_datapath u_dp (
		.clk(clk),
		.rst_n(rst_n),
		.data_in(data_in),
		.iv_in(iv_in),
		.iv_load(iv_load),
		.data_out(data_out),
		.ctl(ctl_if.dp),
		.key(key_if.dp)
	);

	aes_key_schedule u_ks (
		.clk(clk),
		.rst_n(rst_n),
		.key_in(key_in),
		.key_out(key_out),
		.ctl(ctl_if.ks),
		.key(key_if.ks)
	);

endmodule

/* aes_col_ctl_if.sv */
// Control unit strobes and selects toward datapath and key schedule
interface aes_col_ctl_if import aes_col_pkg::*; ();

	// Datapath selects
	sbox_src_t sbox_sel;
	rk_src_t rk_sel;
	col_src_t col_sel;
	col_mask_t col_en;
	logic bypass_rk;
	logic iv_cnt_en;
	logic last_round;
	// Key schedule selects
	col_mask_t key_en;
	logic [1:0] key_out_sel;
	// Expansion vs host key
	logic key_sel;
	logic bypass_key_en;
	logic key_derive_en;
	logic key_gen;
	logic key_init;
	// Forward or inverse direction, shared
	logic encrypt;

	modport ctl (
		output sbox_sel, rk_sel, col_sel, col_en, key_en, key_out_sel, key_sel,
		output bypass_rk, bypass_key_en, iv_cnt_en, key_derive_en,
		output encrypt, key_gen, last_round, key_init
	);

	modport dp (
		input sbox_sel, rk_sel, col_sel, col_en, bypass_rk, iv_cnt_en,
		input encrypt, last_round
	);

	modport ks (
		input key_en, key_out_sel, key_sel, bypass_key_en, key_derive_en,
		input encrypt, key_gen, key_init
	);

endinterface

/* aes_col_key_if.sv */
// Round-key words and shared S-box path between key schedule and datapath
interface aes_col_key_if import aes_col_pkg::*; ();

	// Word added in AddRoundKey
	word_t rk_word;
	// Key word 3 rotated, for SubWord
	word_t g_word;
	// S-box result returned to the key schedule
	word_t sbox_word;

	modport ks (
		output rk_word, g_word,
		input sbox_word
	);

	modport dp (
		input rk_word, g_word,
		output sbox_word
	);

endinterface

/* aes_col_pkg.sv */
// AES column core package: vector types and control encodings
`include "aes_col_settings.svh"

package aes_col_pkg;

	// ====================
	// Vector types
	// ====================
	typedef logic [`AES_BLOCK_W-1:0] block_t;
	typedef logic [`AES_WORD_W-1:0] word_t;
	// Round counter, 0 to 10
	typedef logic [3:0] round_t;
	// One bit per column or key word
	typedef logic [3:0] col_mask_t;

	// ====================
	// Control encodings
	// ====================
	typedef enum logic [1:0] {
		op_encrypt, op_key_derive, op_decrypt, op_decrypt_derive
	} op_mode_t;

	// S-box input: a state column or the key g-function
	typedef enum logic [2:0] {
		sbox_col0, sbox_col1, sbox_col2, sbox_col3, sbox_g
	} sbox_src_t;

	// Column register write source
	typedef enum logic [1:0] {col_shift_rows, col_add_rk_out, col_input} col_src_t;

	// Round-key adder input
	typedef enum logic [1:0] {rk_column, rk_mixcol_in, rk_mixcol_out} rk_src_t;

	typedef enum logic [3:0] {
		idle, round0_col0, round0_col1, round0_col2, round0_col3,
		round_key, nop,
		round_col0, round_col1, round_col2, round_col3,
		ready, gen_key0, gen_key1, gen_key2, gen_key3
	} ctl_state_t;

endpackage

/* aes_col_settings.svh */
// AES column core settings: round count and datapath widths
`ifndef AES_COL_SETTINGS_SVH
`define AES_COL_SETTINGS_SVH

// ====================
// Cipher geometry
// ====================

// AES-128 round count
`define AES_ROUNDS 10

// Full state, key and IV width
`define AES_BLOCK_W 128

// One column or one key word
`define AES_WORD_W 32

`endif

/* aes_control_unit.sv */
// AES column control unit: FSM and round counter driving column and key strobes
`include "aes_col_settings.svh"

module aes_control_unit import aes_col_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic disable_core,
	input op_mode_t operation_mode,
	input logic ctr_mode,
	output logic end_comp,
	output logic busy,
	aes_col_ctl_if.ctl ctl
);

	ctl_state_t state;
	ctl_state_t next_state;
	round_t rd_cnt;
	logic rd_cnt_en;
	op_mode_t op_q;
	op_mode_t start_mode;
	logic fwd;
	logic last;
	logic gen_phase;

	// CTR always runs the forward cipher
	assign start_mode = ctr_mode ? op_encrypt : operation_mode;

	assign gen_phase = (state == gen_key0) || (state == gen_key1) ||
		(state == gen_key2) || (state == gen_key3);

	// Key expansion loop is always forward
	assign fwd = (op_q == op_encrypt) || (op_q == op_key_derive) || gen_phase;

	assign last = (rd_cnt == round_t'(`AES_ROUNDS));

	// ====================
	// State register
	// ====================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= idle;
		else if (disable_core)
			state <= idle;
		else
			state <= next_state;
	end

	// Mode held for the whole block
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			op_q <= op_encrypt;
		else if (state == idle && start)
			op_q <= start_mode;
	end

	// Round counter, cleared between phases
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rd_cnt <= '0;
		else if (state == idle || (state == gen_key3 && last))
			rd_cnt <= '0;
		else if (rd_cnt_en)
			rd_cnt <= rd_cnt + 4'd1;
	end

	// ====================
	// Next state
	// ====================
	always_comb
	begin
		next_state = state;
		case (state)
			idle:
				if (start)
				begin
					case (start_mode)
						op_encrypt: next_state = round0_col0;
						op_decrypt: next_state = round0_col3;
						default: next_state = gen_key0;
					endcase
				end
			// Initial key add, columns 0..3 forward, 3..0 inverse
			round0_col0: next_state = fwd ? round0_col1 : nop;
			round0_col1: next_state = fwd ? round0_col2 : round0_col0;
			round0_col2: next_state = fwd ? round0_col3 : round0_col1;
			round0_col3: next_state = fwd ? round_key : round0_col2;
			// Inverse: key word 0 is needed only by column 0
			round_key: next_state = fwd ? nop : round_col0;
			nop: next_state = fwd ? round_col0 : round_col3;
			round_col0:
				if (fwd)
					next_state = round_col1;
				else
					next_state = last ? ready : nop;
			round_col1: next_state = fwd ? round_col2 : round_key;
			round_col2: next_state = fwd ? round_col3 : round_col1;
			round_col3:
				if (fwd)
					next_state = last ? ready : round_key;
				else
					next_state = round_col2;
			gen_key0: next_state = gen_key1;
			gen_key1: next_state = gen_key2;
			gen_key2: next_state = gen_key3;
			gen_key3:
				if (!last)
					next_state = gen_key0;
				else
					next_state = (op_q == op_key_derive) ? ready : round0_col3;
			ready: next_state = idle;
			default: next_state = idle;
		endcase
	end

	// ====================
	// Output decode
	// ====================
	always_comb
	begin
		ctl.sbox_sel = sbox_col0;
		ctl.rk_sel = rk_column;
		ctl.col_sel = col_shift_rows;
		ctl.col_en = '0;
		ctl.key_en = '0;
		ctl.key_out_sel = 2'd0;
		ctl.key_sel = 1'b0;
		ctl.bypass_rk = 1'b0;
		ctl.bypass_key_en = 1'b0;
		ctl.iv_cnt_en = 1'b0;
		ctl.key_derive_en = 1'b0;
		ctl.key_gen = 1'b0;
		rd_cnt_en = 1'b0;
		case (state)
			idle:
				if (start)
				begin
					// Block capture, IV steps in CTR
					ctl.col_sel = col_input;
					ctl.col_en = '1;
					ctl.iv_cnt_en = ctr_mode;
				end
			round0_col0, round0_col1, round0_col2, round0_col3:
			begin
				// Plain key add with the stored words
				ctl.sbox_sel = sbox_src_t'(state - round0_col0);
				ctl.key_out_sel = 2'(state - round0_col0);
				ctl.col_sel = col_add_rk_out;
				ctl.col_en = col_mask_t'(4'd1 << (state - round0_col0));
				ctl.bypass_rk = 1'b1;
				ctl.bypass_key_en = 1'b1;
			end
			round_key:
			begin
				ctl.sbox_sel = sbox_g;
				ctl.key_en = 4'b0001;
				ctl.key_sel = 1'b1;
				ctl.key_gen = 1'b1;
				rd_cnt_en = fwd;
			end
			nop:
			begin
				// ShiftRows over the whole state
				ctl.col_en = '1;
				rd_cnt_en = !fwd;
			end
			round_col0, round_col1, round_col2, round_col3:
			begin
				ctl.sbox_sel = sbox_src_t'(state - round_col0);
				ctl.key_out_sel = 2'(state - round_col0);
				ctl.col_sel = col_add_rk_out;
				ctl.col_en = col_mask_t'(4'd1 << (state - round_col0));
				// No MixColumns in the final round
				ctl.rk_sel = (fwd && !last) ? rk_mixcol_out : rk_mixcol_in;
				// Word 0 already updated in round_key
				if (state == round_col0)
					ctl.bypass_key_en = 1'b1;
				else
				begin
					ctl.key_en = col_mask_t'(4'd1 << (state - round_col0));
					ctl.key_sel = 1'b1;
				end
			end
			gen_key0:
			begin
				ctl.sbox_sel = sbox_g;
				ctl.key_en = 4'b0001;
				ctl.key_sel = 1'b1;
				ctl.key_derive_en = 1'b1;
				rd_cnt_en = 1'b1;
			end
			gen_key1, gen_key2, gen_key3:
			begin
				ctl.key_en = col_mask_t'(4'd1 << (state - gen_key0));
				ctl.key_sel = 1'b1;
				ctl.key_derive_en = 1'b1;
			end
			default:
			begin
			end
		endcase
	end

	// Idle direction follows the mode being started
	assign ctl.encrypt = (state == idle) ? (start_mode != op_decrypt) : fwd;
	assign ctl.last_round = last;
	assign ctl.key_init = (state == idle) && start;

	assign end_comp = (state == ready);
	assign busy = (state != idle);

	// ====================
	// Checks
	// ====================
	a_col_en_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(state == idle && !start) |-> (ctl.col_en == '0));

	a_end_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		end_comp |=> !end_comp);

	// Host has no back-pressure, start outside idle is lost
	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> (state == idle));

endmodule

/* aes_datapath.sv */
// AES column datapath: state columns, ShiftRows, MixColumns, AddRoundKey and CTR IV
module aes_datapath import aes_col_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input block_t data_in,
	input block_t iv_in,
	input logic iv_load,
	output block_t data_out,
	aes_col_ctl_if.dp ctl,
	aes_col_key_if.dp key
);

	word_t col [4];
	block_t iv_q;
	// Input block for the CTR XOR, zero in ECB
	block_t din_q;
	block_t state_blk;
	block_t shifted;
	word_t sel_col;
	word_t sbox_in;
	word_t sb;
	word_t mc_fwd;
	word_t ark_in;
	word_t ark;
	word_t col_val;
	logic sbox_inv;
	logic load;

	function automatic logic [7:0] xt(input logic [7:0] x);
		return {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
	endfunction

	// Product with a 4-bit constant
	function automatic logic [7:0] cmul(input logic [7:0] x, input logic [3:0] c);
		logic [7:0] x2;
		logic [7:0] x4;
		x2 = xt(x);
		x4 = xt(x2);
		return (c[0] ? x : 8'h00) ^ (c[1] ? x2 : 8'h00) ^ (c[2] ? x4 : 8'h00) ^
			(c[3] ? xt(x4) : 8'h00);
	endfunction

	// Row r of a word is byte [31-8r -: 8]
	function automatic word_t mix(input word_t w, input logic inv);
		logic [7:0] a [4];
		word_t r;
		for (int i = 0; i < 4; i++)
			a[i] = w[31-8*i -: 8];
		for (int i = 0; i < 4; i++)
		begin
			if (inv)
				r[31-8*i -: 8] = cmul(a[i], 4'd14) ^ cmul(a[(i+1)%4], 4'd11) ^
					cmul(a[(i+2)%4], 4'd13) ^ cmul(a[(i+3)%4], 4'd9);
			else
				r[31-8*i -: 8] = cmul(a[i], 4'd2) ^ cmul(a[(i+1)%4], 4'd3) ^
					a[(i+2)%4] ^ a[(i+3)%4];
		end
		return r;
	endfunction

	// Row r rotates left by r, right when inverse
	function automatic block_t shift_rows(input block_t s, input logic inv);
		block_t r;
		int src;
		for (int c = 0; c < 4; c++)
			for (int rw = 0; rw < 4; rw++)
			begin
				src = inv ? (c + 4 - rw) % 4 : (c + rw) % 4;
				r[127-8*(4*c+rw) -: 8] = s[127-8*(4*src+rw) -: 8];
			end
		return r;
	endfunction

	assign state_blk = {col[0], col[1], col[2], col[3]};
	assign shifted = shift_rows(state_blk, !ctl.encrypt);

	// ====================
	// Shared S-box path
	// ====================
	always_comb
	begin
		case (ctl.sbox_sel)
			sbox_col1: sel_col = col[1];
			sbox_col2: sel_col = col[2];
			sbox_col3: sel_col = col[3];
			default: sel_col = col[0];
		endcase
	end

	assign sbox_in = (ctl.sbox_sel == sbox_g) ? key.g_word : sel_col;
	// Key SubWord is always forward
	assign sbox_inv = !ctl.encrypt && (ctl.sbox_sel != sbox_g);

	aes_sbox u_sbox (
		.in_word(sbox_in),
		.inverse(sbox_inv),
		.out_word(sb)
	);

	assign key.sbox_word = sb;

	// ====================
	// MixColumns and key add
	// ====================
	assign mc_fwd = mix(sb, 1'b0);

	always_comb
	begin
		case (ctl.rk_sel)
			rk_mixcol_in: ark_in = sb;
			rk_mixcol_out: ark_in = mc_fwd;
			default: ark_in = sel_col;
		endcase
	end

	assign ark = ark_in ^ key.rk_word;
	// Inverse rounds apply InvMixColumns after the key add
	assign col_val = (!ctl.encrypt && !ctl.last_round && !ctl.bypass_rk) ? mix(ark, 1'b1) : ark;

	assign load = (ctl.col_sel == col_input) && (ctl.col_en == '1);

	// Column registers
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
			if (ctl.col_en[i])
			begin
				case (ctl.col_sel)
					col_input: col[i] <= ctl.iv_cnt_en ? iv_q[127-32*i -: 32] :
						data_in[127-32*i -: 32];
					col_add_rk_out: col[i] <= col_val;
					default: col[i] <= shifted[127-32*i -: 32];
				endcase
			end
	end

	// ====================
	// CTR counter
	// ====================
	always_ff @(posedge clk)
	begin
		if (iv_load)
			iv_q <= iv_in;
		else if (ctl.iv_cnt_en)
			iv_q <= iv_q + 1'b1;
		if (load)
			din_q <= ctl.iv_cnt_en ? data_in : '0;
	end

	assign data_out = state_blk ^ din_q;

	// Key SubWord never collides with a column write
	a_sbox_share: assert property (@(posedge clk) disable iff (!rst_n)
		(ctl.sbox_sel == sbox_g) |-> (ctl.col_en == '0));

endmodule

/* aes_key_schedule.sv */
// AES-128 key schedule: four key words with forward and reverse expansion
module aes_key_schedule import aes_col_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input block_t key_in,
	output block_t key_out,
	aes_col_ctl_if.ks ctl,
	aes_col_key_if.ks key
);

	word_t k [4];
	word_t exp_w [4];
	logic [7:0] rcon;
	logic [7:0] rcon_prev;
	logic [7:0] rcon_use;
	logic rcon_step;

	function automatic logic [7:0] xt(input logic [7:0] x);
		return {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
	endfunction

	// Division by x as the inverse of xt
	function automatic logic [7:0] xt_inv(input logic [7:0] x);
		logic [7:0] y;
		y = x ^ (x[0] ? 8'h1b : 8'h00);
		return {x[0], y[7:1]};
	endfunction

	assign rcon_prev = xt_inv(rcon);
	// Reverse walk uses the constant of the round being undone
	assign rcon_use = ctl.encrypt ? rcon : rcon_prev;
	assign rcon_step = ctl.key_gen || (ctl.key_derive_en && ctl.key_en[0]);

	// RotWord on word 3
	assign key.g_word = {k[3][23:0], k[3][31:24]};

	// ====================
	// Expansion
	// ====================
	// Same chain in both directions with a different word order
	assign exp_w[0] = k[0] ^ key.sbox_word ^ {rcon_use, 24'h0};
	assign exp_w[1] = k[1] ^ k[0];
	assign exp_w[2] = k[2] ^ k[1];
	assign exp_w[3] = k[3] ^ k[2];

	assign key.rk_word = ctl.bypass_key_en ? k[ctl.key_out_sel] : exp_w[ctl.key_out_sel];

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
		begin
			// Host key while key_sel is low
			if (ctl.key_init || ctl.key_en[i])
				k[i] <= ctl.key_sel ? exp_w[i] : key_in[127-32*i -: 32];
		end
	end

	// Round constant register
	// 0x6c is one step past the tenth
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rcon <= 8'h01;
		else if (ctl.key_init)
			rcon <= ctl.encrypt ? 8'h01 : 8'h6c;
		else if (rcon_step)
			rcon <= ctl.encrypt ? xt(rcon) : rcon_prev;
	end

	assign key_out = {k[0], k[1], k[2], k[3]};

endmodule

/* aes_sbox.sv */
// Four-lane AES S-box from GF(2^8) inversion with forward or inverse affine map
module aes_sbox import aes_col_pkg::*;
(
	input word_t in_word,
	input logic inverse,
	output word_t out_word
);

	// GF(2^8) product, AES polynomial
	function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		logic [7:0] aa;
		p = '0;
		aa = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				p = p ^ aa;
			aa = {aa[6:0], 1'b0} ^ (aa[7] ? 8'h1b : 8'h00);
		end
		return p;
	endfunction

	// x^254, zero maps to zero
	function automatic logic [7:0] gf_inv(input logic [7:0] x);
		logic [7:0] sq;
		logic [7:0] acc;
		sq = x;
		acc = 8'h01;
		for (int i = 1; i < 8; i++)
		begin
			sq = gf_mul(sq, sq);
			acc = gf_mul(acc, sq);
		end
		return acc;
	endfunction

	function automatic logic [7:0] rotl(input logic [7:0] x, input int n);
		logic [15:0] d;
		d = {x, x} << n;
		return d[15:8];
	endfunction

	// ====================
	// Byte lanes
	// ====================
	for (genvar g = 0; g < 4; g++)
	begin : g_lane
		logic [7:0] in_b;
		logic [7:0] pre;
		logic [7:0] inv_b;
		logic [7:0] fwd_b;

		assign in_b = in_word[8*g +: 8];
		// Inverse affine goes before the inversion
		assign pre = inverse ? (rotl(in_b, 1) ^ rotl(in_b, 3) ^ rotl(in_b, 6) ^ 8'h05) : in_b;
		assign inv_b = gf_inv(pre);
		// Forward affine after it
		assign fwd_b = inv_b ^ rotl(inv_b, 1) ^ rotl(inv_b, 2) ^ rotl(inv_b, 3) ^
			rotl(inv_b, 4) ^ 8'h63;
		assign out_word[8*g +: 8] = inverse ? inv_b : fwd_b;
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the AES column core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_aes_col_core -f aes_col.f

# The log decides the result, not the exit code of the run
./obj_dir/Vtb_aes_col_core 2>&1 | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
	exit 1
fi
exit 0

/* tb_aes_col_core.sv */
// Testbench for the AES column core: known answers, round trips, CTR and control checks
module tb_aes_col_core import aes_col_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	// ====================
	// Run length
	// ====================
	localparam int clk_period = 20;
	// Upper bound for one block, derive plus decrypt is the longest
	localparam int block_limit = 200;
	localparam int num_blocks = 19;
	// Extra blocks of slack for reset and the aborted block
	localparam int watchdog_cycles = (num_blocks + 3) * block_limit;

	// FIPS-197 Appendix C.1 vectors
	localparam block_t kat_key = 128'h000102030405060708090a0b0c0d0e0f;
	localparam block_t kat_pt = 128'h00112233445566778899aabbccddeeff;
	localparam block_t kat_ct = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	// Tenth round key of the same key
	localparam block_t kat_rk10 = 128'h13111d7fe3944a17f307a78b4d2b30c5;
	localparam block_t ctr_iv = 128'hf0f1f2f3f4f5f6f7f8f9fafbfcfdfeff;

	logic clk;
	logic rst_n;
	logic start;
	logic disable_core;
	op_mode_t operation_mode;
	logic ctr_mode;
	block_t key_in;
	block_t data_in;
	block_t iv_in;
	logic iv_load;
	block_t data_out;
	block_t key_out;
	logic end_comp;
	logic busy;
	// High while no end_comp may appear
	logic abort_window;
	logic [31:0] rng;

	tb_clock_gen #(
		.period_ns(clk_period),
		.reset_cycles(4)
	) u_clk (
		.clk(clk),
		.rst_n(rst_n)
	);

	aes_col_core uut (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.disable_core(disable_core),
		.operation_mode(operation_mode),
		.ctr_mode(ctr_mode),
		.key_in(key_in),
		.data_in(data_in),
		.iv_in(iv_in),
		.iv_load(iv_load),
		.data_out(data_out),
		.key_out(key_out),
		.end_comp(end_comp),
		.busy(busy)
	);

	// ====================
	// Failure reporting
	// ====================
	task automatic stop_on_failure();
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		stop_on_failure();
	endtask

	task automatic check_block(input string name, input block_t expected, input block_t actual);
		assert (actual == expected)
		else
		begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		assert (actual == expected)
		else
		begin
			$display("FAILED %s: expected %b, actual %b", name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond)
		else
			report_failure(what);
	endtask

	// ====================
	// Protocol checks
	// ====================
	// Quiet outputs while in reset
	a_reset_quiet: assert property (@(posedge clk) !rst_n |-> (!end_comp && !busy))
		else report_failure("end_comp or busy high during reset");

	// Single-cycle done, core idle right after
	a_end_single: assert property (@(posedge clk) disable iff (!rst_n)
		end_comp |=> (!end_comp && !busy))
		else report_failure("end_comp not a one-cycle pulse followed by busy low");

	a_no_end_after_abort: assert property (@(posedge clk) disable iff (!rst_n)
		abort_window |-> !end_comp)
		else report_failure("end_comp arrived after disable_core aborted the block");

	// ====================
	// Stimulus helpers
	// ====================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic random_block(output block_t b);
		for (int i = 0; i < 4; i++)
		begin
			rng = xorshift32(rng);
			b[127-32*i -: 32] = rng;
		end
	endtask

	// IV load while idle
	task automatic load_iv(input block_t iv);
		@(posedge clk);
		iv_in <= iv;
		iv_load <= 1'b1;
		@(posedge clk);
		iv_load <= 1'b0;
	endtask

	// One start pulse, then wait for end_comp with a cycle limit
	task automatic run_block(input string name, input op_mode_t op, input logic ctr,
		input block_t key, input block_t din, output block_t dout, output block_t kout);
		int cycles;
		cycles = 0;
		@(posedge clk);
		operation_mode <= op;
		ctr_mode <= ctr;
		key_in <= key;
		data_in <= din;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		check_bit({name, " busy"}, 1'b1, busy);
		// Outputs sampled mid-cycle
		while (!end_comp && cycles < block_limit)
		begin
			@(negedge clk);
			cycles++;
		end
		check_true(end_comp, {"end_comp never arrived for ", name});
		dout = data_out;
		kout = key_out;
	endtask

	// ====================
	// Watchdog
	// ====================
	initial
	begin
		#(watchdog_cycles * clk_period);
		$display("Watchdog expired before the tests completed");
		$display("SOME TESTS FAILED");
		$fatal(1, "timeout");
	end

	// ====================
	// Test sequence
	// ====================
	initial
	begin
		block_t dout;
		block_t kout;
		block_t key_r;
		block_t dkey;
		block_t pt [3];
		block_t ct [3];
		block_t p;
		block_t ks0;
		block_t ks1;
		block_t c0;
		block_t c1;
		block_t p_back;

		rng = 32'hec6a;
		start = 1'b0;
		disable_core = 1'b0;
		operation_mode = op_encrypt;
		ctr_mode = 1'b0;
		key_in = '0;
		data_in = '0;
		iv_in = '0;
		iv_load = 1'b0;
		abort_window = 1'b0;

		@(posedge rst_n);
		@(negedge clk);
		check_bit("reset_end_comp", 1'b0, end_comp);
		check_bit("reset_busy", 1'b0, busy);

		// Known-answer encryption
		run_block("kat_encrypt", op_encrypt, 1'b0, kat_key, kat_pt, dout, kout);
		check_block("kat_encrypt", kat_ct, dout);

		// Key derivation to round 10
		run_block("kat_key_derive", op_key_derive, 1'b0, kat_key, '0, dout, kout);
		check_block("kat_key_derive", kat_rk10, kout);

		// Random key, its derived form feeds plain decryption
		random_block(key_r);
		run_block("rand_key_derive", op_key_derive, 1'b0, key_r, '0, dout, dkey);
		for (int i = 0; i < 3; i++)
		begin
			random_block(pt[i]);
			run_block("rand_encrypt", op_encrypt, 1'b0, key_r, pt[i], ct[i], kout);
		end
		for (int i = 0; i < 3; i++)
		begin
			run_block("rand_decrypt_derive", op_decrypt_derive, 1'b0, key_r, ct[i], dout, kout);
			check_block("rand_decrypt_derive", pt[i], dout);
		end
		for (int i = 0; i < 3; i++)
		begin
			run_block("rand_decrypt", op_decrypt, 1'b0, dkey, ct[i], dout, kout);
			check_block("rand_decrypt", pt[i], dout);
		end

		// CTR keystreams from plain ECB of IV and IV+1
		random_block(p);
		run_block("ctr_keystream0", op_encrypt, 1'b0, key_r, ctr_iv, ks0, kout);
		run_block("ctr_keystream1", op_encrypt, 1'b0, key_r, block_t'(ctr_iv + 128'd1),
			ks1, kout);
		load_iv(ctr_iv);
		run_block("ctr_encrypt", op_encrypt, 1'b1, key_r, p, c0, kout);
		check_block("ctr_encrypt", ks0 ^ p, c0);
		// Decrypt op still runs forward under CTR
		load_iv(ctr_iv);
		run_block("ctr_decrypt", op_decrypt, 1'b1, key_r, c0, p_back, kout);
		check_block("ctr_decrypt", p, p_back);
		// No reload, IV has stepped once
		run_block("ctr_next_block", op_encrypt, 1'b1, key_r, p, c1, kout);
		check_block("ctr_next_block", ks1 ^ p, c1);
		check_true(c1 != c0, "two CTR blocks without IV reload used the same keystream");

		// Abort mid-block
		@(posedge clk);
		operation_mode <= op_encrypt;
		ctr_mode <= 1'b0;
		key_in <= kat_key;
		data_in <= kat_pt;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		check_bit("abort_busy_before", 1'b1, busy);
		repeat (20)
			@(posedge clk);
		disable_core <= 1'b1;
		abort_window <= 1'b1;
		@(posedge clk);
		disable_core <= 1'b0;
		@(negedge clk);
		check_bit("abort_busy_after", 1'b0, busy);
		repeat (block_limit)
			@(posedge clk);
		abort_window <= 1'b0;

		// Full block after the abort
		run_block("kat_after_abort", op_encrypt, 1'b0, kat_key, kat_pt, dout, kout);
		check_block("kat_after_abort", kat_ct, dout);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* tb_clock_gen.sv */
// Testbench clock and reset source for the AES column core
module tb_clock_gen
#(
	parameter int period_ns = 20,
	parameter int reset_cycles = 4
)
(
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	// Free-running clock
	initial
	begin
		clk = 1'b0;
		forever
			#(period_ns / 2) clk = ~clk;
	end

	// Reset held low for a few edges, released on a rising edge
	initial
	begin
		rst_n = 1'b0;
		repeat (reset_cycles)
			@(posedge clk);
		rst_n <= 1'b1;
	end

endmodule
